//--- nic_rx_pkg.sv
`default_nettype none

package nic_rx_pkg;

    // ------------------------------------------------------------------
    // Ring buffer geometry
    // ------------------------------------------------------------------
    localparam int DATA_W    = 64;              // Stream and ring word
    localparam int BUF_AW    = 8;               // Ring address bits
    localparam int BUF_DEPTH = 256;             // Qwords in the ring
    localparam int PTR_W     = BUF_AW + 1;      // Address plus wrap bit

    typedef logic [PTR_W-1:0] ptr_t;            // Ring pointer with wrap bit

    // ------------------------------------------------------------------
    // Burst and flow control
    // ------------------------------------------------------------------
    localparam int MAX_TLP_QWORDS = 16;         // Largest burst per TLP
    localparam int QCNT_W         = 5;          // Holds 0..16
    localparam int TLP_CREDITS    = 4;          // Credits held after reset
    localparam int CRED_W         = $clog2(TLP_CREDITS + 1);
    localparam int SEQ_W          = 8;          // TLP sequence number

    // Sender FSM encoding
    localparam int               SND_STATE_W = 2;
    localparam logic [SND_STATE_W-1:0] SND_IDLE = 2'd0;   // Waiting for request
    localparam logic [SND_STATE_W-1:0] SND_HDR  = 2'd1;   // Header word out
    localparam logic [SND_STATE_W-1:0] SND_DATA = 2'd2;   // Payload words out

    // ------------------------------------------------------------------
    // TLP word layout
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [DATA_W-SEQ_W-QCNT_W-BUF_AW-1:0] pad;         // Zero fill
        logic [SEQ_W-1:0]                      seq;         // Running TLP number
        logic [QCNT_W-1:0]                     qword_count; // Burst length
        logic [BUF_AW-1:0]                     ring_offset; // First qword slot
    } tlp_hdr_t;

    // One output word, header view or payload view
    typedef union packed {
        tlp_hdr_t          hdr;
        logic [DATA_W-1:0] raw;
    } tlp_word_u;

endpackage

`default_nettype wire

//--- tlp_trigger_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tlp_trigger_if import nic_rx_pkg::*; ();

    logic              trigger_tlp;         // Burst request
    logic              trigger_tlp_ack;     // One-cycle accept pulse
    logic [QCNT_W-1:0] qwords_to_send;      // Burst length, 1..16
    ptr_t              tlp_start_address;   // Pointer of first qword

    // Request side, held stable until the ack
    modport trigger (
        output trigger_tlp,
        output qwords_to_send,
        output tlp_start_address,
        input  trigger_tlp_ack
    );

    // Accept side
    modport sender (
        input  trigger_tlp,
        input  qwords_to_send,
        input  tlp_start_address,
        output trigger_tlp_ack
    );

endinterface

`default_nettype wire

//--- rx_mac_writer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_mac_writer import nic_rx_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // MAC receive stream
    input  logic [DATA_W-1:0] s_axis_tdata,
    input  logic              s_axis_tvalid,
    input  logic              s_axis_tlast,
    output logic              s_axis_tready,
    // Ring write port
    output logic [BUF_AW-1:0] wr_addr,
    output logic [DATA_W-1:0] wr_data,
    output logic              wr_en,
    // Pointer exchange with the read side
    output ptr_t              commited_wr_address,
    input  ptr_t              commited_rd_address
);

    // ------------------------------------------------------------------
    // Running write pointer and fill level
    // ------------------------------------------------------------------
    ptr_t wr_ptr;           // Next free slot, wrap bit on top
    ptr_t wr_ptr_nxt;       // Slot after the current one
    ptr_t fill_level;       // Qwords not yet released by the sender
    logic ring_full;        // No free slot left
    logic beat_ok;          // Beat taken on this edge

    assign wr_ptr_nxt = wr_ptr + ptr_t'(1);

    // Counts partial frames too, they occupy slots already
    assign fill_level = wr_ptr - commited_rd_address;
    assign ring_full  = (fill_level == ptr_t'(BUF_DEPTH));   // Wrap bits differ

    assign s_axis_tready = !ring_full;                        // Back-pressure
    assign beat_ok       = s_axis_tvalid && s_axis_tready;    // AXI handshake

    // ------------------------------------------------------------------
    // Ring write, lands on the accept edge
    // ------------------------------------------------------------------
    assign wr_en   = beat_ok;
    assign wr_addr = wr_ptr[BUF_AW-1:0];      // Drop wrap bit
    assign wr_data = s_axis_tdata;

    // ------------------------------------------------------------------
    // Pointer update and frame commit
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr              <= '0;
            commited_wr_address <= '0;
        end else if (beat_ok) begin
            wr_ptr <= wr_ptr_nxt;                   // One qword per beat
            if (s_axis_tlast) begin
                commited_wr_address <= wr_ptr_nxt;  // Whole frame now visible
            end
        end
    end

    // Mid-frame beats leave the committed pointer alone, so the
    // trigger stage never cuts into a frame still arriving

endmodule

`default_nettype wire

//--- rx_frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_buffer import nic_rx_pkg::*; (
    input  logic              clk,
    // Write port, MAC side
    input  logic [BUF_AW-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              wr_en,
    // Read port, TLP side
    input  logic [BUF_AW-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------
    logic [DATA_W-1:0] mem [0:BUF_DEPTH-1];   // Ring of qwords

    // Synchronous write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Same-address read and write returns the old word, the sender
    // only reads slots committed earlier

endmodule

`default_nettype wire

//--- rx_tlp_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module rx_tlp_trigger import nic_rx_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  ptr_t           commited_wr_address,   // Frame-end pointer from writer
    tlp_trigger_if.trigger trig                   // Burst request to sender
);

    // ------------------------------------------------------------------
    // Committed but not yet issued data
    // ------------------------------------------------------------------
    ptr_t              issued_ptr;    // First qword not handed to sender
    ptr_t              unissued;      // Qwords waiting for a burst
    logic [QCNT_W-1:0] burst_len;     // Clamped burst size

    assign unissued = commited_wr_address - issued_ptr;

    // Cap at one full TLP
    assign burst_len = (unissued > ptr_t'(MAX_TLP_QWORDS)) ?
                       QCNT_W'(MAX_TLP_QWORDS) : unissued[QCNT_W-1:0];

    // ------------------------------------------------------------------
    // Request handshake
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            issued_ptr       <= '0;
            trig.trigger_tlp <= 1'b0;
        end else if (trig.trigger_tlp) begin
            if (trig.trigger_tlp_ack) begin
                trig.trigger_tlp <= 1'b0;     // Drop right after the ack
                issued_ptr       <= issued_ptr + ptr_t'(trig.qwords_to_send);
            end
        end else if (unissued != '0) begin
            trig.trigger_tlp <= 1'b1;         // New data committed
        end
    end

    // ------------------------------------------------------------------
    // Request payload
    // ------------------------------------------------------------------
    // Tracks the live values while idle and freezes once the request
    // is up, so count and address stay put until the ack
    always_ff @(posedge clk) begin
        if (!trig.trigger_tlp) begin
            trig.qwords_to_send    <= burst_len;
            trig.tlp_start_address <= issued_ptr;
        end
    end

endmodule

`default_nettype wire

//--- rx_tlp_sender.sv
`timescale 1ns/1ps
`default_nettype none

module rx_tlp_sender import nic_rx_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              credit_return,        // One credit back per pulse
    tlp_trigger_if.sender     trig,                 // Burst request from trigger
    // Ring read port
    output logic [BUF_AW-1:0] rd_addr,
    input  logic [DATA_W-1:0] rd_data,
    // Host-side TLP stream
    output logic [DATA_W-1:0] tlp_data,
    output logic              tlp_valid,
    output logic              tlp_sof,
    output logic              tlp_eof,
    // Released ring space, back to the writer
    output ptr_t              commited_rd_address
);

    // ------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------
    logic [SND_STATE_W-1:0] state;        // FSM state
    logic [CRED_W-1:0]      credits;      // TLPs the host can still absorb
    logic [SEQ_W-1:0]       seq;          // Number of the next TLP
    logic [QCNT_W-1:0]      remaining;    // Data words left in this TLP
    ptr_t                   rd_ptr;       // Next ring slot to read
    logic                   take;         // Request accepted this cycle
    tlp_word_u              hdr_word;     // Header assembly

    // Accept only when idle and holding a credit
    assign take = trig.trigger_tlp && (state == SND_IDLE) && (credits != '0);
    assign trig.trigger_tlp_ack = take;

    // ------------------------------------------------------------------
    // Credit counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CRED_W'(TLP_CREDITS);
        end else begin
            case ({take, credit_return})
                2'b10:   credits <= credits - CRED_W'(1);   // Spent on a TLP
                2'b01:   credits <= credits + CRED_W'(1);   // Host consumed one
                default: credits <= credits;                // Both or neither
            endcase
        end
    end

    // ------------------------------------------------------------------
    // FSM and read pointer
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state               <= SND_IDLE;
            seq                 <= '0;
            remaining           <= '0;
            rd_ptr              <= '0;
            commited_rd_address <= '0;
        end else begin
            case (state)
                SND_IDLE: begin
                    if (take) begin
                        state     <= SND_HDR;
                        rd_ptr    <= trig.tlp_start_address;  // Latch burst
                        remaining <= trig.qwords_to_send;
                    end
                end
                SND_HDR: begin
                    // First slot is on rd_addr now, data lands next cycle
                    state  <= SND_DATA;
                    rd_ptr <= rd_ptr + ptr_t'(1);
                    seq    <= seq + SEQ_W'(1);
                end
                SND_DATA: begin
                    rd_ptr    <= rd_ptr + ptr_t'(1);          // Stay one ahead
                    remaining <= remaining - QCNT_W'(1);
                    if (remaining == QCNT_W'(1)) begin
                        state               <= SND_IDLE;
                        commited_rd_address <= rd_ptr;        // Start plus count
                    end
                end
                default: begin
                    state <= SND_IDLE;                        // Unused code
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Header word
    // ------------------------------------------------------------------
    // In SND_HDR rd_ptr still holds the burst start and remaining the
    // full count, so both go straight into the header
    always_comb begin
        hdr_word                 = '0;
        hdr_word.hdr.pad         = '0;
        hdr_word.hdr.seq         = seq;
        hdr_word.hdr.qword_count = remaining;
        hdr_word.hdr.ring_offset = rd_ptr[BUF_AW-1:0];
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign rd_addr   = rd_ptr[BUF_AW-1:0];
    assign tlp_valid = (state != SND_IDLE);
    assign tlp_sof   = (state == SND_HDR);
    assign tlp_eof   = (state == SND_DATA) && (remaining == QCNT_W'(1));
    assign tlp_data  = tlp_sof ? hdr_word.raw : rd_data;   // Payload from ring

endmodule

`default_nettype wire

//--- nic_rx_dma.sv
`timescale 1ns/1ps
`default_nettype none

module nic_rx_dma import nic_rx_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // MAC receive stream
    input  logic [DATA_W-1:0] s_axis_tdata,
    input  logic              s_axis_tvalid,
    input  logic              s_axis_tlast,
    output logic              s_axis_tready,
    // Host TLP stream
    output logic [DATA_W-1:0] tlp_data,
    output logic              tlp_valid,
    output logic              tlp_sof,
    output logic              tlp_eof,
    input  logic              credit_return
);

    // ------------------------------------------------------------------
    // Local wires
    // ------------------------------------------------------------------
    logic [BUF_AW-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              wr_en;
    logic [BUF_AW-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;
    ptr_t              commited_wr_address;   // Writer to trigger
    ptr_t              commited_rd_address;   // Sender to writer

    tlp_trigger_if trig_if ();                 // Trigger to sender handshake

    // ------------------------------------------------------------------
    // MAC side writer
    // ------------------------------------------------------------------
    rx_mac_writer rx_mac_writer_i (
        .clk                 (clk),                   // I
        .reset               (reset),                 // I
        .s_axis_tdata        (s_axis_tdata),          // I [63:0]
        .s_axis_tvalid       (s_axis_tvalid),         // I
        .s_axis_tlast        (s_axis_tlast),          // I
        .s_axis_tready       (s_axis_tready),         // O
        .wr_addr             (wr_addr),               // O [7:0]
        .wr_data             (wr_data),               // O [63:0]
        .wr_en               (wr_en),                 // O
        .commited_wr_address (commited_wr_address),   // O [8:0]
        .commited_rd_address (commited_rd_address)    // I [8:0]
    );

    // ------------------------------------------------------------------
    // Ring memory
    // ------------------------------------------------------------------
    rx_frame_buffer rx_frame_buffer_i (
        .clk     (clk),        // I
        .wr_addr (wr_addr),    // I [7:0]
        .wr_data (wr_data),    // I [63:0]
        .wr_en   (wr_en),      // I
        .rd_addr (rd_addr),    // I [7:0]
        .rd_data (rd_data)     // O [63:0]
    );

    // ------------------------------------------------------------------
    // Burst trigger
    // ------------------------------------------------------------------
    rx_tlp_trigger rx_tlp_trigger_i (
        .clk                 (clk),                   // I
        .reset               (reset),                 // I
        .commited_wr_address (commited_wr_address),   // I [8:0]
        .trig                (trig_if.trigger)        // Request out
    );

    // ------------------------------------------------------------------
    // TLP sender
    // ------------------------------------------------------------------
    rx_tlp_sender rx_tlp_sender_i (
        .clk                 (clk),                   // I
        .reset               (reset),                 // I
        .credit_return       (credit_return),         // I
        .trig                (trig_if.sender),        // Ack out
        .rd_addr             (rd_addr),               // O [7:0]
        .rd_data             (rd_data),               // I [63:0]
        .tlp_data            (tlp_data),              // O [63:0]
        .tlp_valid           (tlp_valid),             // O
        .tlp_sof             (tlp_sof),               // O
        .tlp_eof             (tlp_eof),               // O
        .commited_rd_address (commited_rd_address)    // O [8:0]
    );

endmodule

`default_nettype wire

//--- tb_nic_rx_dma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nic_rx_dma import nic_rx_pkg::*; ();

    localparam int TOTAL_BEATS = 10 + 40 + 96 + 663;              // Random part at its maximum
    localparam int WD_CYCLES   = (TOTAL_BEATS * 4 * 3) / 2 + 2000;

    logic              clk;
    logic              reset;
    logic [DATA_W-1:0] s_axis_tdata;
    logic              s_axis_tvalid;
    logic              s_axis_tlast;
    logic              s_axis_tready;
    logic [DATA_W-1:0] tlp_data;
    logic              tlp_valid;
    logic              tlp_sof;
    logic              tlp_eof;
    logic              credit_return;
    tlp_word_u         tlp_w;                 // Output word in header view

    logic [DATA_W-1:0] sb [$];                // Accepted payload in order
    int                exp_counts [$];        // Burst lengths for directed frames
    int                seed = 40;
    logic [DATA_W-1:0] next_word;             // Payload counter
    logic              beat_taken;            // Beat accepted on last edge
    logic              any_beat;
    logic              saw_full;              // tready seen low
    logic [SEQ_W-1:0]  exp_seq;
    int                rem;                   // Data words still due in this TLP
    int                accept_count;
    int                out_count;             // Data words seen on the output
    int                sof_count;
    int                eof_count;
    int                returned_count;
    int                credit_limit;          // Returns allowed while held
    logic              hold_credits;

    assign tlp_w = tlp_data;

    nic_rx_dma dut_i (
        .clk           (clk),
        .reset         (reset),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tready (s_axis_tready),
        .tlp_data      (tlp_data),
        .tlp_valid     (tlp_valid),
        .tlp_sof       (tlp_sof),
        .tlp_eof       (tlp_eof),
        .credit_return (credit_return)
    );

    task automatic fail_now(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // ----------------------------------------------------------------------
    // Clock and watchdog
    // ----------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                // 4 ns period
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout: the DUT did not finish the tests in time");
        $display("Regression failed");
        $fatal(1);
    end

    // ----------------------------------------------------------------------
    // Monitor and scoreboard
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        beat_taken <= s_axis_tvalid && s_axis_tready;
        if (!s_axis_tready) saw_full <= 1'b1;
        if (s_axis_tvalid && s_axis_tready) begin
            sb.push_back(s_axis_tdata);       // Payload now owned by DUT
            any_beat     <= 1'b1;
            accept_count <= accept_count + 1;
        end
        if (tlp_sof) begin
            assert (tlp_w.hdr.qword_count != '0 && int'(tlp_w.hdr.qword_count) <= MAX_TLP_QWORDS)
                else fail_now("header count out of range");
            assert (tlp_w.hdr.pad == '0) else fail_now("header pad bits not zero");
            assert (tlp_w.hdr.seq == exp_seq) else fail_now("header sequence number wrong");
            assert (tlp_w.hdr.ring_offset == out_count[BUF_AW-1:0])
                else fail_now("header ring offset wrong");
            assert (int'(tlp_w.hdr.qword_count) <= sb.size())
                else fail_now("TLP announces uncommitted data");
            if (exp_counts.size() != 0) begin
                assert (int'(tlp_w.hdr.qword_count) == exp_counts[0])
                    else fail_now("burst length differs from the frame cut");
                void'(exp_counts.pop_front());
            end
            rem       <= int'(tlp_w.hdr.qword_count);
            exp_seq   <= exp_seq + SEQ_W'(1);
            sof_count <= sof_count + 1;
        end else if (tlp_valid) begin
            assert (sb.size() != 0 && sb[0] == tlp_data) else fail_now("payload mismatch");
            void'(sb.pop_front());
            rem       <= rem - 1;
            out_count <= out_count + 1;
            if (tlp_eof) eof_count <= eof_count + 1;
        end
    end

    // Protocol rules on the rising edge
    a_idle:   assert property (@(posedge clk) disable iff (reset)
                  !any_beat |-> !tlp_valid && s_axis_tready)
              else fail_now("activity before the first beat");
    a_burst:  assert property (@(posedge clk) disable iff (reset)
                  rem != 0 |-> tlp_valid && !tlp_sof)
              else fail_now("gap or new header inside a TLP");
    a_stray:  assert property (@(posedge clk) disable iff (reset)
                  tlp_valid && !tlp_sof |-> rem != 0)
              else fail_now("data word outside a TLP");
    a_eof:    assert property (@(posedge clk) disable iff (reset)
                  tlp_valid && !tlp_sof |-> tlp_eof == (rem == 1))
              else fail_now("eof on the wrong word");
    a_sof:    assert property (@(posedge clk) disable iff (reset)
                  tlp_sof |-> tlp_valid && !tlp_eof)
              else fail_now("malformed header word");
    a_credit: assert property (@(posedge clk) disable iff (reset)
                  sof_count <= TLP_CREDITS + returned_count)
              else fail_now("TLP sent without a credit");
    a_fill:   assert property (@(posedge clk) disable iff (reset)
                  accept_count <= out_count + BUF_DEPTH)
              else fail_now("ring overfilled");

    // ----------------------------------------------------------------------
    // Host credit return
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset && returned_count < eof_count &&
            (!hold_credits || returned_count < credit_limit)) begin
            credit_return  = 1'b1;            // One TLP consumed
            returned_count = returned_count + 1;
        end else begin
            credit_return = 1'b0;
        end
    end

    task automatic send_frame(input int len, input bit gaps);
        int i;
        int g;
        for (i = 0; i < len; i++) begin
            if (gaps) begin
                g = $random(seed) & 7;
                if (g > 4) begin
                    s_axis_tvalid = 1'b0;     // Idle gap
                    repeat (g - 4) @(negedge clk);
                end
            end
            s_axis_tvalid = 1'b1;
            s_axis_tdata  = next_word;
            s_axis_tlast  = (i == len - 1);
            @(negedge clk);
            while (!beat_taken) @(negedge clk);
            next_word = next_word + DATA_W'(1);
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    task automatic wait_drain();
        wait (out_count == accept_count && rem == 0);
        repeat (4) @(negedge clk);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        int total;
        int len;
        reset = 1'b1;
        s_axis_tdata = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast = 1'b0;
        credit_return = 1'b0;
        next_word = '0;
        beat_taken = 1'b0;
        any_beat = 1'b0;
        saw_full = 1'b0;
        exp_seq = '0;
        rem = 0;
        accept_count = 0;
        out_count = 0;
        sof_count = 0;
        eof_count = 0;
        returned_count = 0;
        credit_limit = 0;
        hold_credits = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (5) @(negedge clk);

        exp_counts.push_back(10);             // Short frame in a single TLP
        send_frame(10, 1'b0);
        wait_drain();
        exp_counts = '{16, 16, 8};            // Long frame cut in bursts
        send_frame(40, 1'b0);
        wait_drain();

        hold_credits = 1'b1;                  // Credits held back
        credit_limit = returned_count;
        repeat (6) send_frame(16, 1'b0);
        wait (sof_count == TLP_CREDITS + returned_count);
        repeat (40) @(negedge clk);
        credit_limit = credit_limit + 1;      // Exactly one returned
        wait (returned_count == credit_limit);
        wait (sof_count == TLP_CREDITS + returned_count);

        fork
            begin
                total = 0;
                while (total < 600) begin
                    len = 1 + ($random(seed) & 63);
                    send_frame(len, 1'b1);
                    total = total + len;
                end
            end
            begin
                wait (saw_full);
                repeat (50) @(negedge clk);
                hold_credits = 1'b0;          // Host drains again
            end
        join
        wait_drain();

        if (sb.size() == 0 && saw_full && exp_counts.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_now("data left in the scoreboard or ring never filled");
        end
    end

endmodule

`default_nettype wire

//--- nic_rx_dma.f
nic_rx_pkg.sv
tlp_trigger_if.sv
rx_mac_writer.sv
rx_frame_buffer.sv
rx_tlp_trigger.sv
rx_tlp_sender.sv
nic_rx_dma.sv
tb_nic_rx_dma.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_nic_rx_dma -f nic_rx_dma.f; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_nic_rx_dma 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$out"; then
    exit 0
fi
exit 1
